/* design/cnn_settings.svh */
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// Side length of one square feature map
`define FMAP_DIM 28

// Output channels held by the stage
`define NUM_CHANNELS 8

// Store, pool and read services sharing the memory
`define NUM_REQUESTERS 3

`endif

/* design/cnn_types_pkg.sv */
`default_nettype none

`include "cnn_settings.svh"

package cnn_types_pkg;

    typedef logic signed [7:0] pixel_t;
    typedef logic [$clog2(`NUM_CHANNELS)-1:0] channel_t;
    typedef logic [$clog2(`FMAP_DIM * `FMAP_DIM)-1:0] pixel_addr_t;  // Row-major in one map

    // Pooling pass sequencing
    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT,       // Last pixel of a window still returning
        WRITE,
        FINISH
    } pool_state_t;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    // Arbiter port index of each service
    typedef enum logic [1:0] {
        REQ_STORE,
        REQ_POOL,
        REQ_READ
    } requester_t;

endpackage

`default_nettype wire

/* design/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
;

    logic        req;
    mem_op_t     op;
    channel_t    channel;
    pixel_addr_t addr;
    pixel_t      wdata;

    logic        gnt;       // Same-cycle accept
    pixel_t      rdata;
    logic        rvalid;    // One cycle after an accepted read

    modport requester (
        output req, op, channel, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport server (
        input  req, op, channel, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

/* design/result_banks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_settings.svh"

module result_banks
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    mem_port_if.server mem
);

    localparam int MAP_SIZE = `FMAP_DIM * `FMAP_DIM;
    localparam int DEPTH    = `NUM_CHANNELS * MAP_SIZE;
    localparam int AW       = $clog2(DEPTH);

    pixel_t        mem_array [DEPTH];
    logic [AW-1:0] flat_addr;
    logic          rd_en;
    logic          wr_en;

    // Channels stacked one map after another
    assign flat_addr = AW'(mem.channel) * AW'(MAP_SIZE) + AW'(mem.addr);
    assign rd_en     = mem.req && (mem.op == MEM_READ);
    assign wr_en     = mem.req && (mem.op == MEM_WRITE);

    assign mem.gnt = mem.req;   // Single port never stalls

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem_array[flat_addr] <= mem.wdata;
        if (rd_en)
            mem.rdata <= mem_array[flat_addr];
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            mem.rvalid <= 1'b0;
        else
            mem.rvalid <= rd_en;
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_settings.svh"

module mem_arbiter
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int NUM_PORTS = `NUM_REQUESTERS
)
(
    input logic           clk,
    input logic           rst,
    mem_port_if.server    ports [NUM_PORTS],
    mem_port_if.requester mem
);

    localparam int IW = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [NUM_PORTS-1:0] req_vec;
    logic [NUM_PORTS-1:0] gnt_vec;
    mem_op_t              op_arr    [NUM_PORTS];
    channel_t             ch_arr    [NUM_PORTS];
    pixel_addr_t          addr_arr  [NUM_PORTS];
    pixel_t               wdata_arr [NUM_PORTS];
    logic [IW-1:0]        ptr;        // Highest priority this cycle
    logic [IW-1:0]        sel;
    logic                 sel_valid;
    logic [IW-1:0]        rd_owner;   // Port of the last accepted read
    logic                 accept;

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        assign req_vec[i]       = ports[i].req;
        assign op_arr[i]        = ports[i].op;
        assign ch_arr[i]        = ports[i].channel;
        assign addr_arr[i]      = ports[i].addr;
        assign wdata_arr[i]     = ports[i].wdata;
        assign ports[i].gnt     = gnt_vec[i];
        assign ports[i].rdata   = mem.rdata;
        assign ports[i].rvalid  = mem.rvalid && (rd_owner == IW'(i));
    end

    // First requester at or after the pointer wins
    always_comb
    begin
        int idx;
        sel       = '0;
        sel_valid = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            idx = (int'(ptr) + k) % NUM_PORTS;
            if (!sel_valid && req_vec[idx])
            begin
                sel       = IW'(idx);
                sel_valid = 1'b1;
            end
        end
    end

    always_comb
    begin
        gnt_vec = '0;
        if (sel_valid)
            gnt_vec[sel] = mem.gnt;
    end

    assign mem.req     = sel_valid;
    assign mem.op      = op_arr[sel];
    assign mem.channel = ch_arr[sel];
    assign mem.addr    = addr_arr[sel];
    assign mem.wdata   = wdata_arr[sel];
    assign accept      = mem.req && mem.gnt;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ptr      <= '0;
            rd_owner <= '0;
        end
        else if (accept)
        begin
            ptr <= (int'(sel) == NUM_PORTS - 1) ? '0 : sel + 1'b1;
            if (mem.op == MEM_READ)
                rd_owner <= sel;
        end
    end

endmodule

`default_nettype wire

/* design/result_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module result_accumulator
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          store_req,
    output logic          store_ack,
    input  channel_t      store_channel,
    input  pixel_addr_t   store_addr,
    input  pixel_t        bias,
    input  pixel_t        value,
    input  logic          first_write,
    mem_port_if.requester mem
);

    typedef enum logic [2:0] {
        ACC_IDLE,
        ACC_READ,
        ACC_WAIT,
        ACC_WRITE,
        ACC_ACK
    } acc_state_t;

    acc_state_t         state;
    logic signed [8:0]  sum;     // Old plus new, one guard bit
    pixel_t             avg_q;

    assign sum = 9'(mem.rdata) + 9'(value);

    // Host holds channel, address and data while store_req is high
    assign mem.req     = (state == ACC_READ) || (state == ACC_WRITE);
    assign mem.op      = (state == ACC_WRITE) ? MEM_WRITE : MEM_READ;
    assign mem.channel = store_channel;
    assign mem.addr    = store_addr;
    assign mem.wdata   = first_write ? bias : avg_q;
    assign store_ack   = (state == ACC_ACK);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= ACC_IDLE;
        else
        begin
            case (state)
                ACC_IDLE:  if (store_req) state <= first_write ? ACC_WRITE : ACC_READ;
                ACC_READ:  if (mem.gnt) state <= ACC_WAIT;
                ACC_WAIT:  if (mem.rvalid) state <= ACC_WRITE;
                ACC_WRITE: if (mem.gnt) state <= ACC_ACK;
                ACC_ACK:   if (!store_req) state <= ACC_IDLE;
                default:   state <= ACC_IDLE;
            endcase
        end
    end

    // Average of old and new, rounding towards minus infinity
    always_ff @(posedge clk)
    begin
        if (state == ACC_WAIT && mem.rvalid)
            avg_q <= pixel_t'(sum >>> 1);
    end

endmodule

`default_nettype wire

/* design/max_pool_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_settings.svh"

module max_pool_engine
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          pool_req,
    output logic          pool_ack,
    mem_port_if.requester mem
);

    localparam int DIM = `FMAP_DIM;
    localparam int CW  = $clog2(DIM);

    pool_state_t  state;
    channel_t     ch_q;
    logic [CW-1:0] row_q;      // Top row of the window
    logic [CW-1:0] col_q;      // Left column of the window
    logic [1:0]   tap_q;       // Next pixel to request
    logic [1:0]   ret_q;       // Pixels returned so far
    pixel_t       max_q;
    pixel_addr_t  base;
    pixel_addr_t  offset;
    logic         last_col;
    logic         last_row;
    logic         last_ch;

    assign base     = pixel_addr_t'(row_q) * pixel_addr_t'(DIM) + pixel_addr_t'(col_q);
    assign offset   = (tap_q[1] ? pixel_addr_t'(DIM) : '0) + pixel_addr_t'(tap_q[0]);
    assign last_col = (col_q == CW'(DIM - 2));
    assign last_row = (row_q == CW'(DIM - 2));
    assign last_ch  = (ch_q == channel_t'(`NUM_CHANNELS - 1));

    assign mem.req     = (state == READ) || (state == WRITE);
    assign mem.op      = (state == WRITE) ? MEM_WRITE : MEM_READ;
    assign mem.channel = ch_q;
    assign mem.addr    = (state == WRITE) ? base : base + offset;
    assign mem.wdata   = max_q[7] ? '0 : max_q;   // ReLU
    assign pool_ack    = (state == FINISH);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= IDLE;
            ch_q  <= '0;
            row_q <= '0;
            col_q <= '0;
            tap_q <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (pool_req)
                    begin
                        state <= READ;
                        ch_q  <= '0;
                        row_q <= '0;
                        col_q <= '0;
                        tap_q <= '0;
                    end
                READ:
                    if (mem.gnt)
                    begin
                        tap_q <= tap_q + 2'd1;
                        if (tap_q == 2'd3)
                            state <= WAIT;
                    end
                WAIT:
                    if (mem.rvalid && ret_q == 2'd3)
                        state <= WRITE;
                WRITE:
                    if (mem.gnt)
                    begin
                        state <= READ;
                        col_q <= last_col ? '0 : col_q + CW'(2);
                        if (last_col)
                            row_q <= last_row ? '0 : row_q + CW'(2);
                        if (last_col && last_row)
                        begin
                            ch_q <= ch_q + 1'b1;
                            if (last_ch)
                                state <= FINISH;
                        end
                    end
                FINISH:
                    if (!pool_req)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            ret_q <= '0;
        else if (mem.rvalid)
            ret_q <= ret_q + 2'd1;
    end

    // Running maximum, restarted by the first pixel of each window
    always_ff @(posedge clk)
    begin
        if (mem.rvalid && (ret_q == 2'd0 || mem.rdata > max_q))
            max_q <= mem.rdata;
    end

endmodule

`default_nettype wire

/* design/result_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module result_readout
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          rd_req,
    output logic          rd_ack,
    input  channel_t      rd_channel,
    input  pixel_addr_t   rd_addr,
    output pixel_t        rd_data,
    mem_port_if.requester mem
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_READ,
        RD_WAIT,
        RD_ACK
    } rd_state_t;

    rd_state_t state;

    assign mem.req     = (state == RD_READ);
    assign mem.op      = MEM_READ;
    assign mem.channel = rd_channel;
    assign mem.addr    = rd_addr;
    assign mem.wdata   = '0;     // Read only port
    assign rd_ack      = (state == RD_ACK);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= RD_IDLE;
        else
        begin
            case (state)
                RD_IDLE: if (rd_req) state <= RD_READ;
                RD_READ: if (mem.gnt) state <= RD_WAIT;
                RD_WAIT: if (mem.rvalid) state <= RD_ACK;
                RD_ACK:  if (!rd_req) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Held for the host until the next read
    always_ff @(posedge clk)
    begin
        if (state == RD_WAIT && mem.rvalid)
            rd_data <= mem.rdata;
    end

endmodule

`default_nettype wire

/* design/cnn_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_settings.svh"

module cnn_result_stage
    import cnn_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        store_req,
    output logic        store_ack,
    input  channel_t    store_channel,
    input  pixel_addr_t store_addr,
    input  pixel_t      bias,
    input  pixel_t      value,
    input  logic        first_write,

    input  logic        pool_req,
    output logic        pool_ack,

    input  logic        rd_req,
    output logic        rd_ack,
    input  channel_t    rd_channel,
    input  pixel_addr_t rd_addr,
    output pixel_t      rd_data
);

    mem_port_if req_ports [`NUM_REQUESTERS] ();   // One per service
    mem_port_if bank_port ();

    result_accumulator i_result_accumulator (
        .clk           (clk),
        .rst           (rst),
        .store_req     (store_req),
        .store_ack     (store_ack),
        .store_channel (store_channel),
        .store_addr    (store_addr),
        .bias          (bias),
        .value         (value),
        .first_write   (first_write),
        .mem           (req_ports[REQ_STORE])
    );

    max_pool_engine i_max_pool_engine (
        .clk      (clk),
        .rst      (rst),
        .pool_req (pool_req),
        .pool_ack (pool_ack),
        .mem      (req_ports[REQ_POOL])
    );

    result_readout i_result_readout (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (rd_req),
        .rd_ack     (rd_ack),
        .rd_channel (rd_channel),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .mem        (req_ports[REQ_READ])
    );

    mem_arbiter #(
        .NUM_PORTS (`NUM_REQUESTERS)
    ) i_mem_arbiter (
        .clk   (clk),
        .rst   (rst),
        .ports (req_ports),
        .mem   (bank_port)
    );

    result_banks i_result_banks (
        .clk (clk),
        .rst (rst),
        .mem (bank_port)
    );

endmodule

`default_nettype wire

/* testbench/tb_cnn_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_settings.svh"

module tb_cnn_result_stage
    import cnn_types_pkg::*;
();

    localparam int DIM          = `FMAP_DIM;
    localparam int MAP_SIZE     = DIM * DIM;
    localparam int NCH          = `NUM_CHANNELS;
    localparam int POOL_CYCLES  = NCH * MAP_SIZE * 4;
    localparam int OP_CYCLES    = 800 * 16;        // Stores and reads with handshake overhead
    localparam int LIMIT_CYCLES = POOL_CYCLES + OP_CYCLES + 1000;
    localparam int PROBE_ADDR   = (DIM - 1) * DIM + (DIM - 1);   // Bottom-right corner
    localparam int SIDE_ADDR    = 21 * DIM + 21;
    localparam int HOLD_CYCLES  = 2;               // Req kept up after ack

    logic        clk;
    logic        rst;
    logic        store_req;
    logic        store_ack;
    channel_t    store_channel;
    pixel_addr_t store_addr;
    pixel_t      bias;
    pixel_t      value;
    logic        first_write;
    logic        pool_req;
    logic        pool_ack;
    logic        rd_req;
    logic        rd_ack;
    channel_t    rd_channel;
    pixel_addr_t rd_addr;
    pixel_t      rd_data;

    pixel_t model_mem     [NCH * MAP_SIZE];
    logic   model_written [NCH * MAP_SIZE];
    int     error_count;
    int     check_count;
    integer seed = 32'h0eeb_db17;
    time    store_ack_time;
    time    pool_ack_time;

    cnn_result_stage i_cnn_result_stage (.*);

    always #2 clk = ~clk;

    task automatic note_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    // Each ack follows its req and holds until the req falls
    assert property (@(posedge clk) disable iff (!rst) store_ack && store_req |=> store_ack)
        else note_failure("store_ack dropped while store_req was still high");
    assert property (@(posedge clk) disable iff (!rst) $rose(store_ack) |-> store_req)
        else note_failure("store_ack rose without store_req");
    assert property (@(posedge clk) disable iff (!rst) pool_ack && pool_req |=> pool_ack)
        else note_failure("pool_ack dropped while pool_req was still high");
    assert property (@(posedge clk) disable iff (!rst) $rose(pool_ack) |-> pool_req)
        else note_failure("pool_ack rose without pool_req");
    assert property (@(posedge clk) disable iff (!rst) rd_ack && rd_req |=> rd_ack)
        else note_failure("rd_ack dropped while rd_req was still high");
    assert property (@(posedge clk) disable iff (!rst) $rose(rd_ack) |-> rd_req)
        else note_failure("rd_ack rose without rd_req");

    function automatic int flat(input int ch, input int addr);
        return ch * MAP_SIZE + addr;
    endfunction

    // Sign-extended sum with the lowest bit dropped
    function automatic pixel_t shifted_average(input pixel_t old_px, input pixel_t new_px);
        logic [8:0] s;
        s = {old_px[7], old_px} + {new_px[7], new_px};
        return s[8:1];
    endfunction

    function automatic pixel_t pooled(input pixel_t a, input pixel_t b,
                                      input pixel_t c, input pixel_t d);
        pixel_t m;
        m = a;
        if (b > m)
            m = b;
        if (c > m)
            m = c;
        if (d > m)
            m = d;
        return (m < 0) ? 8'sd0 : m;
    endfunction

    function automatic pixel_t rand_pixel(input logic negative);
        pixel_t p;
        p = pixel_t'($random(seed));
        if (negative)
            p[7] = 1'b1;
        return p;
    endfunction

    task automatic do_store(input int ch, input int addr, input logic fw,
                            input pixel_t b, input pixel_t v);
        int idx;
        idx = flat(ch, addr);
        @(negedge clk);
        store_channel = channel_t'(ch);
        store_addr    = pixel_addr_t'(addr);
        bias          = b;
        value         = v;
        first_write   = fw;
        store_req     = 1'b1;
        do @(negedge clk); while (!store_ack);
        store_ack_time = $time;
        repeat (HOLD_CYCLES) @(negedge clk);
        store_req = 1'b0;
        do @(negedge clk); while (store_ack);
        if (fw)
            model_mem[idx] = b;
        else
            model_mem[idx] = shifted_average(model_mem[idx], v);
        model_written[idx] = 1'b1;
    endtask

    task automatic do_read(input int ch, input int addr, output pixel_t data);
        @(negedge clk);
        rd_channel = channel_t'(ch);
        rd_addr    = pixel_addr_t'(addr);
        rd_req     = 1'b1;
        do @(negedge clk); while (!rd_ack);
        data   = rd_data;   // Held while rd_ack is high
        repeat (HOLD_CYCLES) @(negedge clk);
        rd_req = 1'b0;
        do @(negedge clk); while (rd_ack);
    endtask

    task automatic do_pool();
        @(negedge clk);
        pool_req = 1'b1;
        do @(negedge clk); while (!pool_ack);
        pool_ack_time = $time;
        repeat (HOLD_CYCLES) @(negedge clk);
        pool_req = 1'b0;
        do @(negedge clk); while (pool_ack);
    endtask

    task automatic check_pixel(input int ch, input int addr);
        pixel_t got;
        pixel_t exp;
        do_read(ch, addr, got);
        exp = model_mem[flat(ch, addr)];
        check_count++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: rd_data ch %0d addr %0d expected %0d got %0d",
                     $time, ch, addr, exp, got);
            error_count++;
        end
    endtask

    // Top-left gets the pooled value only where the whole window is known
    task automatic update_pool_model();
        int tl;
        for (int ch = 0; ch < NCH; ch++)
            for (int wr = 0; wr < DIM; wr += 2)
                for (int wc = 0; wc < DIM; wc += 2)
                begin
                    tl = flat(ch, wr * DIM + wc);
                    if (model_written[tl] && model_written[tl + 1] &&
                        model_written[tl + DIM] && model_written[tl + DIM + 1])
                        model_mem[tl] = pooled(model_mem[tl], model_mem[tl + 1],
                                               model_mem[tl + DIM], model_mem[tl + DIM + 1]);
                    else
                        model_written[tl] = 1'b0;
                end
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s finished, %0d errors so far", num, name, error_count);
    endtask

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", LIMIT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        clk           = 1'b0;
        rst           = 1'b0;
        store_req     = 1'b0;
        store_channel = '0;
        store_addr    = '0;
        bias          = '0;
        value         = '0;
        first_write   = 1'b0;
        pool_req      = 1'b0;
        rd_req        = 1'b0;
        rd_channel    = '0;
        rd_addr       = '0;
        error_count   = 0;
        check_count   = 0;
        for (int i = 0; i < NCH * MAP_SIZE; i++)
            model_written[i] = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        @(negedge clk);
        check_count++;
        assert (!store_ack && !pool_ack && !rd_ack)
            else note_failure("An ack output is high right after reset");
        report_test(1, "ack state after reset");

        // Distinct bias per channel at one address
        for (int ch = 0; ch < NCH; ch++)
            do_store(ch, PROBE_ADDR, 1'b1, pixel_t'(ch * 16 - 60), 8'sd0);
        for (int ch = 0; ch < NCH; ch++)
            check_pixel(ch, PROBE_ADDR);
        report_test(2, "bias load per channel");

        // Top-left 4x4 corner of every map with some windows forced negative
        for (int ch = 0; ch < NCH; ch++)
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    do_store(ch, r * DIM + c, 1'b1,
                             rand_pixel(((r / 2 + c / 2 + ch) % 3) == 0), 8'sd0);
        for (int round = 0; round < 2; round++)
            for (int ch = 0; ch < NCH; ch++)
                for (int r = 0; r < 4; r++)
                    for (int c = 0; c < 4; c++)
                        do_store(ch, r * DIM + c, 1'b0, 8'sd0,
                                 rand_pixel(((r / 2 + c / 2 + ch) % 3) == 0));
        for (int ch = 0; ch < NCH; ch++)
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    check_pixel(ch, r * DIM + c);
        report_test(3, "averaging stores");

        do_store(NCH - 1, SIDE_ADDR, 1'b1, rand_pixel(1'b0), 8'sd0);
        fork
            do_pool();
            begin
                repeat (20) @(negedge clk);
                do_store(NCH - 1, SIDE_ADDR, 1'b0, 8'sd0, rand_pixel(1'b0));
            end
        join
        update_pool_model();
        for (int ch = 0; ch < NCH; ch++)
            for (int wr = 0; wr < DIM; wr += 2)
                for (int wc = 0; wc < DIM; wc += 2)
                    if (model_written[flat(ch, wr * DIM + wc)])
                        check_pixel(ch, wr * DIM + wc);
        report_test(4, "max pool with ReLU");

        check_count++;
        assert (store_ack_time < pool_ack_time)
            else note_failure("Store issued during pooling was not acknowledged before pool_ack");
        check_pixel(NCH - 1, SIDE_ADDR);
        report_test(5, "store during pooling");

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/cnn_types_pkg.sv
design/mem_bus_pkg.sv
design/mem_port_if.sv
design/result_banks.sv
design/mem_arbiter.sv
design/result_accumulator.sv
design/max_pool_engine.sv
design/result_readout.sv
design/cnn_result_stage.sv
testbench/tb_cnn_result_stage.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_cnn_result_stage
RTL_TOP   ?= cnn_result_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
